//--- bench/bus_input.txt
# op f1 f2 f3 f4 in hex: K code pressed, J joy0 joy1, S cart_size, W addr
# A addr wr ram_addr we_n, D addr ram_data cpu_data, C addr cru_in
C EC04 0
K 015 1
C EC04 1
K 007 1
C EC04 1
C EC00 0
K 015 0
C EC04 0
C 0000 1
J 00000040 00000000
C EC00 1
C EC50 0
J 00000000 00000000
C EC00 0
A 9000 0 4800 1
S 02000
W E10C
A 9000 0 8800 1
S 08000
A 5000 0 8800 1
W E108
A 9000 0 4800 1
A F002 1 7801 0
A 4000 1 2000 0
A 8000 1 4000 0
A 6000 1 3000 1
A C000 1 6000 1
A F002 0 7801 1
D E100 1234 0000
D 9000 BEEF BEEF
D E800 5A5A 5A5A

//--- bench/tutor_bus_tb.sv
// ********************
// Tutor bus testbench
// Replays the operations of the stimulus file against the bus glue
// ********************
module tutor_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import tutor_pkg::*;

	localparam string INPUT_FILE = "bench/bus_input.txt";

	typedef logic [3:0][31:0] args_t;

	logic        clk;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [15:0] cpu_data;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [16:0] cart_size;
	logic [10:0] ps2_key;
	logic [31:0] joy0;
	logic [31:0] joy1;
	logic [15:0] ram_data;
	logic [15:0] ram_addr;
	logic        ram_we_n;
	logic [15:0] rd_data;
	logic        cru_in;

	logic [7:0]  op_q[$];
	args_t       arg_q[$];
	int          cycle_cnt = 0;
	int          cycle_limit = 0;  // Set once the file is read

	tutor_bus #(.SYSTEM_TYPE(TUTOR), .RAM_EXPAND_MASK(5'b00101)) DUT (
		.clk(clk), .reset(reset),
		.cpu_addr_i(cpu_addr), .cpu_data_i(cpu_data), .cpu_rd_i(cpu_rd), .cpu_wr_i(cpu_wr),
		.cart_size_i(cart_size), .ps2_key_i(ps2_key), .joy0_i(joy0), .joy1_i(joy1),
		.ram_data_i(ram_data), .ram_addr_o(ram_addr), .ram_we_n_o(ram_we_n),
		.cpu_data_o(rd_data), .cru_in_o(cru_in));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [15:0] addr,
			input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
		else stop_with_failure($sformatf(
			"CHECK FAILED at %0d ns: %s at address %h is %h, expected %h",
			$time, what, addr, got, exp));
	endtask

	task automatic load_ops;
		int         fd;
		int         n;
		string      line;
		logic [7:0] op;
		logic [31:0] a0, a1, a2, a3;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			stop_with_failure("Could not open the stimulus file bench/bus_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin  // Skip blank and comment lines
					a0 = '0;
					a1 = '0;
					a2 = '0;
					a3 = '0;
					n = $sscanf(line, "%c %h %h %h %h", op, a0, a1, a2, a3);
					op_q.push_back(op);
					arg_q.push_back({a3, a2, a1, a0});
				end
			end
			$fclose(fd);
		end
	endtask

	// Runs one file line from 1 ns after a rising edge
	task automatic run_op(input logic [7:0] op, input args_t a);
		@(posedge clk);
		#1;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		case (op)
			"K": begin
				ps2_key = {~ps2_key[10], a[1][0], a[0][8:0]};  // Flip toggle for a new event
				@(posedge clk);
				#1;
			end
			"J": begin
				joy0 = a[0];
				joy1 = a[1];
			end
			"S": cart_size = a[0][16:0];
			"W": begin
				cpu_addr = a[0][15:0];
				cpu_wr   = 1'b1;
				@(posedge clk);
				#1;
				cpu_wr   = 1'b0;
			end
			"A": begin
				cpu_addr = a[0][15:0];
				cpu_wr   = a[1][0];
				#5;
				check_value("ram_addr_o", cpu_addr, 32'(ram_addr), a[2]);
				check_value("ram_we_n_o", cpu_addr, 32'(ram_we_n), a[3]);
			end
			"D": begin
				cpu_addr = a[0][15:0];
				cpu_rd   = 1'b1;
				ram_data = a[1][15:0];
				#5;
				check_value("cpu_data_o", cpu_addr, 32'(rd_data), a[2]);
			end
			"C": begin
				cpu_addr = a[0][15:0];
				#5;
				check_value("cru_in_o", cpu_addr, 32'(cru_in), a[1]);
			end
			default: stop_with_failure($sformatf("Unknown operation %c in the stimulus file", op));
		endcase
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			stop_with_failure("Timeout, the operations did not finish within the cycle limit");
	end

	initial begin
		reset     = 1'b1;
		cpu_addr  = '0;
		cpu_data  = '0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cart_size = '0;
		ps2_key   = '0;
		joy0      = '0;
		joy1      = '0;
		ram_data  = '0;
		load_ops();
		cycle_limit = op_q.size() * 4 + 50;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		foreach (op_q[i])
			run_op(op_q[i], arg_q[i]);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the Tutor bus testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f tutor_bus.f --top-module tutor_bus_tb -o tutor_sim

# The simulator exits non-zero on a failure, the log decides the result
./obj_dir/tutor_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run_sim: testbench passed"
else
	echo "run_sim: testbench failed"
	exit 1
fi

//--- src/bus_read_mux.sv
// ********************
// CPU read data and CRU input select
// ********************
module bus_read_mux #(
	parameter tutor_pkg::system_t SYSTEM_TYPE = tutor_pkg::TUTOR
) (
	input  tutor_pkg::cpu_bus_t  bus_i,
	input  tutor_pkg::key_rows_t rows_i,
	input  logic [15:0]          ram_data_i,
	output logic [15:0]          cpu_data_o,
	output logic                 cru_in_o
);
	import tutor_pkg::*;

	localparam logic [7:0] UTIL_PAGE = 8'hE1;  // Utility block, reads zero

	logic [15:0] addr;
	logic        jr_sel;
	logic [7:0]  jr_row;

	assign addr   = bus_i.addr;
	assign jr_sel = (SYSTEM_TYPE == PYUTA_JR) && (addr[15:11] == JR_KBD_SEL);

	always_comb begin
		case (addr)
			JR_ROW0_ADDR: jr_row = rows_i.jr[0];
			JR_ROW1_ADDR: jr_row = rows_i.jr[1];
			JR_ROW2_ADDR: jr_row = rows_i.jr[2];
			JR_ROW3_ADDR: jr_row = rows_i.jr[3];
			default:      jr_row = 8'h00;
		endcase
	end

	always_comb begin
		if (jr_sel)
			cpu_data_o = {jr_row, 8'h00};  // Row on the high byte
		else if (addr[15:8] == UTIL_PAGE)
			cpu_data_o = 16'h0000;
		else
			cpu_data_o = ram_data_i;
	end

	// Unselected CRU bits float high
	assign cru_in_o = (bus_i.addr.cru.kbd_sel == KBD_CRU_SEL) ?
		rows_i.tutor[bus_i.addr.cru.key_idx] : 1'b1;

endmodule

//--- src/cart_mapper.sv
// ********************
// Cartridge memory mapper
// Cart enable latch, banked RAM word address and RAM write enable
// ********************
module cart_mapper #(
	parameter tutor_pkg::system_t SYSTEM_TYPE     = tutor_pkg::TUTOR,
	parameter logic [4:0]         RAM_EXPAND_MASK = 5'b00000
) (
	input  logic                clk,
	input  logic                reset,
	input  tutor_pkg::cpu_bus_t bus_i,
	input  logic [16:0]         cart_size_i,
	output logic [15:0]         ram_addr_o,
	output logic                ram_we_n_o
);
	import tutor_pkg::*;

	logic        cart_en;
	logic [15:0] addr;
	logic [15:0] word_addr;
	logic        banked;
	logic        large_hit;
	logic        small_hit;
	logic [2:0]  blk;
	logic        exp_hit;

	assign addr      = bus_i.addr;
	assign word_addr = {1'b0, bus_i.addr.mem.word};
	assign blk       = addr[15:13];  // 8K block number

	always_ff @(posedge clk) begin
		if (reset) begin
			cart_en <= 1'b0;
		end else if (bus_i.wr) begin
			if (addr == CART_OFF_ADDR)
				cart_en <= 1'b0;
			else if (addr == CART_ON_ADDR)
				cart_en <= 1'b1;
		end
	end

	// Pyuta variants always see the cartridge
	assign banked = cart_en || (SYSTEM_TYPE != TUTOR);

	assign large_hit = banked && (cart_size_i > CART_SMALL_LIMIT) &&
		(addr >= 16'h4000) && (addr <= 16'hBFFF);
	assign small_hit = banked && (cart_size_i <= CART_SMALL_LIMIT) &&
		(addr >= 16'h8000) && (addr <= 16'hBFFF);

	always_comb begin
		if (large_hit)
			ram_addr_o = word_addr + BANK_OFF_LARGE;
		else if (small_hit)
			ram_addr_o = word_addr + BANK_OFF_SMALL;
		else
			ram_addr_o = word_addr;
	end

	// Expansion RAM has one mask bit per 8K block from 4000
	always_comb begin
		case (blk)
			3'd2:    exp_hit = RAM_EXPAND_MASK[0];
			3'd3:    exp_hit = RAM_EXPAND_MASK[1];
			3'd4:    exp_hit = RAM_EXPAND_MASK[2];
			3'd5:    exp_hit = RAM_EXPAND_MASK[3];
			3'd6:    exp_hit = RAM_EXPAND_MASK[4];
			default: exp_hit = 1'b0;
		endcase
	end

	assign ram_we_n_o = !(bus_i.wr && ((addr[15:12] == 4'hF) || exp_hit));

	// Writes need the CPU strobe and never reach the ROM below 4000 or the I/O page
	a_we_window: assert property (@(posedge clk) disable iff (reset)
		!ram_we_n_o |-> bus_i.wr && (addr >= 16'h4000) && (addr[15:12] != 4'hE))
		else $error("RAM write enable outside the writable windows");

endmodule

//--- src/key_matrix.sv
// ********************
// Keyboard and joystick matrix
// Tracks PS/2 key states and builds the Tutor matrix and Jr scan rows
// ********************
module key_matrix (
	input  logic                   clk,
	input  logic                   reset,
	input  tutor_pkg::ps2_event_t  ps2_i,
	input  logic [31:0]            joy0_i,
	input  logic [31:0]            joy1_i,
	output tutor_pkg::key_rows_t   rows_o
);
	import tutor_pkg::*;

	// Positions that no key or joystick line drives
	localparam logic [0:63] FIXED_ZERO = 64'h0000_0000_00C0_840F;

	logic        toggle_q;
	logic [0:63] key_q;      // Indexed by Tutor matrix position
	logic [0:63] joy_bits;
	logic [6:0]  lookup;     // Hit flag and matrix position
	logic        ps2_evt;

	// Scan code to matrix position, bit 6 flags a known key
	function automatic logic [6:0] key_lookup(input logic [7:0] code);
		logic [6:0] hit;
		hit = 7'd0;
		case (code)
			8'h16: hit = {1'b1, 6'd0};   // 1
			8'h1E: hit = {1'b1, 6'd1};   // 2
			8'h15: hit = {1'b1, 6'd2};   // q
			8'h1D: hit = {1'b1, 6'd3};   // w
			8'h1C: hit = {1'b1, 6'd4};   // a
			8'h1B: hit = {1'b1, 6'd5};   // s
			8'h1A: hit = {1'b1, 6'd6};   // z
			8'h22: hit = {1'b1, 6'd7};   // x
			8'h26: hit = {1'b1, 6'd8};   // 3
			8'h25: hit = {1'b1, 6'd9};   // 4
			8'h24: hit = {1'b1, 6'd10};  // e
			8'h2D: hit = {1'b1, 6'd11};  // r
			8'h23: hit = {1'b1, 6'd12};  // d
			8'h2B: hit = {1'b1, 6'd13};  // f
			8'h21: hit = {1'b1, 6'd14};  // c
			8'h2A: hit = {1'b1, 6'd15};  // v
			8'h2E: hit = {1'b1, 6'd16};  // 5
			8'h36: hit = {1'b1, 6'd17};  // 6
			8'h2C: hit = {1'b1, 6'd18};  // t
			8'h35: hit = {1'b1, 6'd19};  // y
			8'h34: hit = {1'b1, 6'd20};  // g
			8'h33: hit = {1'b1, 6'd21};  // h
			8'h32: hit = {1'b1, 6'd22};  // b
			8'h31: hit = {1'b1, 6'd23};  // n
			8'h3D: hit = {1'b1, 6'd24};  // 7
			8'h3E: hit = {1'b1, 6'd25};  // 8
			8'h46: hit = {1'b1, 6'd26};  // 9
			8'h3C: hit = {1'b1, 6'd27};  // u
			8'h43: hit = {1'b1, 6'd28};  // i
			8'h3B: hit = {1'b1, 6'd29};  // j
			8'h42: hit = {1'b1, 6'd30};  // k
			8'h3A: hit = {1'b1, 6'd31};  // m
			8'h45: hit = {1'b1, 6'd32};  // 0
			8'h4E: hit = {1'b1, 6'd33};  // -
			8'h44: hit = {1'b1, 6'd34};  // o
			8'h4D: hit = {1'b1, 6'd35};  // p
			8'h4B: hit = {1'b1, 6'd36};  // l
			8'h4C: hit = {1'b1, 6'd37};  // ;
			8'h41: hit = {1'b1, 6'd38};  // ,
			8'h49: hit = {1'b1, 6'd39};  // .
			8'h55: hit = {1'b1, 6'd42};  // = as degree
			8'h54: hit = {1'b1, 6'd43};  // [ as underscore
			8'h52: hit = {1'b1, 6'd44};  // Quote as colon
			8'h5B: hit = {1'b1, 6'd45};  // ] as open bracket
			8'h4A: hit = {1'b1, 6'd46};  // /
			8'h5D: hit = {1'b1, 6'd47};  // \ as close bracket
			8'h58: hit = {1'b1, 6'd49};  // Caps as alpha lock
			8'h12: hit = {1'b1, 6'd50};  // Left shift
			8'h59: hit = {1'b1, 6'd50};  // Right shift, same key
			8'h05: hit = {1'b1, 6'd51};  // F1 as MON
			8'h5A: hit = {1'b1, 6'd52};  // Enter
			8'h06: hit = {1'b1, 6'd54};  // F2 as MOD
			8'h29: hit = {1'b1, 6'd55};  // Space
			8'h6B: hit = {1'b1, 6'd56};  // Cursor left
			8'h66: hit = {1'b1, 6'd56};  // Backspace shares cursor left
			8'h75: hit = {1'b1, 6'd57};  // Cursor up
			8'h72: hit = {1'b1, 6'd58};  // Cursor down
			8'h74: hit = {1'b1, 6'd59};  // Cursor right
			default: hit = 7'd0;
		endcase
		return hit;
	endfunction

	assign ps2_evt = (ps2_i.toggle != toggle_q);
	assign lookup  = key_lookup(ps2_i.code[7:0]);  // Extended prefix bit ignored

	always_ff @(posedge clk) begin
		toggle_q <= ps2_i.toggle;  // Also loaded in reset, no false event
		if (reset) begin
			key_q <= '0;
		end else if (ps2_evt && lookup[6]) begin
			key_q[lookup[5:0]] <= ps2_i.pressed;
		end
	end

	// Joystick lines wired onto the Tutor keys
	always_comb begin
		joy_bits     = '0;
		joy_bits[0]  = joy0_i[6];
		joy_bits[1]  = joy0_i[7];
		joy_bits[34] = joy0_i[4];
		joy_bits[35] = joy0_i[5];
		joy_bits[36] = joy0_i[2];
		joy_bits[37] = joy0_i[1];
		joy_bits[38] = joy0_i[3];
		joy_bits[39] = joy0_i[0];
		joy_bits[42] = joy1_i[4];
		joy_bits[43] = joy1_i[5];
		joy_bits[44] = joy1_i[2];
		joy_bits[45] = joy1_i[1];
		joy_bits[46] = joy1_i[3];
		joy_bits[47] = joy1_i[0];
		joy_bits[52] = joy0_i[8];
		joy_bits[56] = joy0_i[1];
		joy_bits[57] = joy0_i[3];
		joy_bits[58] = joy0_i[2];
		joy_bits[59] = joy0_i[0];
	end

	always_comb begin
		rows_o.tutor = key_q | joy_bits;
		// Jr rows, first listed bit lands on D7
		rows_o.jr[0] = {joy0_i[0], joy0_i[3], joy0_i[1], joy0_i[2],
			joy0_i[5], joy0_i[4], 2'b00};
		rows_o.jr[1] = {key_q[1] | joy0_i[7], key_q[0] | joy0_i[6],
			key_q[51] | key_q[2], key_q[54] | key_q[31], key_q[35],
			key_q[52] | joy0_i[8], 2'b00};
		rows_o.jr[2] = {key_q[59] | joy0_i[0], key_q[58] | joy0_i[2],
			key_q[57] | joy0_i[3], key_q[56] | joy0_i[1], key_q[39], key_q[38], 2'b00};
		rows_o.jr[3] = {joy1_i[0], joy1_i[3], joy1_i[1], joy1_i[2],
			joy1_i[5], joy1_i[4], 2'b00};
	end

	// Decoder never reaches the unused matrix positions
	a_fixed_zero: assert property (@(posedge clk) disable iff (reset)
		(rows_o.tutor & FIXED_ZERO) == '0)
		else $error("Fixed-zero matrix position set");

endmodule

//--- src/tutor_bus.sv
// ********************
// Tutor CPU bus glue
// Keyboard matrix, cartridge mapper and read select around the TMS9995
// ********************
module tutor_bus #(
	parameter tutor_pkg::system_t SYSTEM_TYPE     = tutor_pkg::TUTOR,
	parameter logic [4:0]         RAM_EXPAND_MASK = 5'b00000
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] cpu_addr_i,
	input  logic [15:0] cpu_data_i,
	input  logic        cpu_rd_i,
	input  logic        cpu_wr_i,
	input  logic [16:0] cart_size_i,
	input  logic [10:0] ps2_key_i,
	input  logic [31:0] joy0_i,
	input  logic [31:0] joy1_i,
	input  logic [15:0] ram_data_i,
	output logic [15:0] ram_addr_o,
	output logic        ram_we_n_o,
	output logic [15:0] cpu_data_o,
	output logic        cru_in_o
);
	import tutor_pkg::*;

	cpu_bus_t   bus;
	ps2_event_t ps2_ev;
	key_rows_t  rows;

	assign bus    = {cpu_addr_i, cpu_data_i, cpu_rd_i, cpu_wr_i};
	assign ps2_ev = ps2_event_t'(ps2_key_i);

	key_matrix u_keys (.clk(clk), .reset(reset), .ps2_i(ps2_ev),
		.joy0_i(joy0_i), .joy1_i(joy1_i), .rows_o(rows));

	cart_mapper #(.SYSTEM_TYPE(SYSTEM_TYPE), .RAM_EXPAND_MASK(RAM_EXPAND_MASK)) u_mapper (
		.clk(clk), .reset(reset), .bus_i(bus), .cart_size_i(cart_size_i),
		.ram_addr_o(ram_addr_o), .ram_we_n_o(ram_we_n_o));

	bus_read_mux #(.SYSTEM_TYPE(SYSTEM_TYPE)) u_read (.bus_i(bus), .rows_i(rows),
		.ram_data_i(ram_data_i), .cpu_data_o(cpu_data_o), .cru_in_o(cru_in_o));

endmodule

//--- src/tutor_pkg.sv
// ********************
// Tutor bus definitions
// Address map constants, machine type and the structs shared by the
// CPU-side glue blocks
// ********************
package tutor_pkg;

	// Machine variant
	typedef enum logic [1:0] {
		TUTOR    = 2'd0,
		PYUTA    = 2'd1,
		PYUTA_JR = 2'd2
	} system_t;

	// Cartridge enable latch strobes
	localparam logic [15:0] CART_OFF_ADDR = 16'hE108;
	localparam logic [15:0] CART_ON_ADDR  = 16'hE10C;

	// Pyuta Jr keyboard rows, read as memory
	localparam logic [15:0] JR_ROW0_ADDR = 16'hE800;
	localparam logic [15:0] JR_ROW1_ADDR = 16'hEA00;
	localparam logic [15:0] JR_ROW2_ADDR = 16'hEC00;
	localparam logic [15:0] JR_ROW3_ADDR = 16'hEE00;

	localparam logic [8:0]  KBD_CRU_SEL      = 9'h1D8;    // CRU EC00-EC7F
	localparam logic [4:0]  JR_KBD_SEL       = 5'h1D;     // E800-EFFF
	localparam logic [16:0] CART_SMALL_LIMIT = 17'h04000; // 16K

	// Word offsets of the cartridge image in external RAM
	localparam logic [15:0] BANK_OFF_LARGE = 16'h6000;
	localparam logic [15:0] BANK_OFF_SMALL = 16'h4000;

	typedef struct packed {
		logic [14:0] word;
		logic        byte_sel;
	} mem_view_t;

	typedef struct packed {
		logic [8:0] kbd_sel;
		logic [5:0] key_idx;  // Address bits 6..1
		logic       low;
	} cru_view_t;

	// Same CPU address, seen as memory or as CRU bit address
	typedef union packed {
		mem_view_t mem;
		cru_view_t cru;
	} cpu_addr_u;

	typedef struct packed {
		cpu_addr_u   addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
	} cpu_bus_t;

	// PS/2 event word, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_event_t;

	typedef struct packed {
		logic [0:63]     tutor;  // Index equals CRU key index
		logic [3:0][7:0] jr;     // Row 0 at E800 up to row 3 at EE00
	} key_rows_t;

endpackage

//--- tutor_bus.f
src/tutor_pkg.sv
src/key_matrix.sv
src/cart_mapper.sv
src/bus_read_mux.sv
src/tutor_bus.sv
bench/tutor_bus_tb.sv
